/* design/bdHostDefs_defs.svh */
`ifndef BD_HOST_DEFS_SVH
`define BD_HOST_DEFS_SVH

// ------------------------------------------------------------
// bank and datapath sizing
// ------------------------------------------------------------

// spike generators in the bank
`define BD_NUM_GENS 4

// host words and chip words share one width
`define BD_WORD_W 32

// ------------------------------------------------------------
// generator and queue sizing
// ------------------------------------------------------------

// period and start-tick fields of a generator program
`define BD_PERIOD_W 16

// pass-through queue entries, keep a power of two
`define BD_QUEUE_DEPTH 4

`endif

/* design/bdWordPkg.sv */
package bdWordPkg;

  // ------------------------------------------------------------
  // host word, one 32-bit word read two ways
  // ------------------------------------------------------------

  // ep view:  [3] endpoint id, [2:0] 24-bit payload
  // rg view:  [1] kind(15:14) reg id(13:8) pad(7:0), [0] data
  typedef union packed {
    logic [3:0][7:0]  ep;
    logic [1:0][15:0] rg;
  } hostWord_u;

  // ------------------------------------------------------------
  // word kinds, top two bits of either view
  // ------------------------------------------------------------

  localparam logic [1:0] KIND_BD  = 2'b00;  // chip word, passed through
  localparam logic [1:0] KIND_EP  = 2'b01;  // endpoint write
  localparam logic [1:0] KIND_REG = 2'b10;  // register write
  // kind 11 is a channel write, not handled here

  // register ids, 6 bits

  // bit 0 holds the core in soft reset
  localparam logic [5:0] REG_RESET = 6'd31;
  // highest id, never backed by a register
  localparam logic [5:0] REG_NOP   = 6'd63;

  // ------------------------------------------------------------
  // endpoint ids, full 8 bits incl. kind
  // ------------------------------------------------------------

  localparam logic [7:0] EP_GENS_USED  = 8'd69;   // generators in use
  localparam logic [7:0] EP_GEN_ENABLE = 8'd70;   // per-generator enable mask
  localparam logic [7:0] EP_GEN_PROG   = 8'd112;  // program piece, 16 bits at a time

endpackage

/* design/spikeGenPkg.sv */
`include "bdHostDefs_defs.svh"

package spikeGenPkg;

  // ------------------------------------------------------------
  // assembled program, low 52 of the 64 shifted-in bits
  // ------------------------------------------------------------

  localparam int PROG_TAG_LSB    = 0;
  localparam int PROG_TAG_W      = 11;
  localparam int PROG_TICKS_LSB  = 11;           // start value of the count
  localparam int PROG_PERIOD_LSB = 27;
  localparam int PROG_GEN_LSB    = 43;           // target generator
  localparam int PROG_GEN_W      = 8;
  localparam int PROG_SIGN_BIT   = 51;
  localparam int PROG_W          = 52;

  // ticks and period are both BD_PERIOD_W wide
  localparam int PROG_TIME_W = `BD_PERIOD_W;

  // ------------------------------------------------------------
  // spike word out to the chip
  // ------------------------------------------------------------

  localparam logic [1:0] SPIKE_KIND = 2'b01;

  // kind 31:30, sign 29, gen 28:21, tag 20:10, zero below
  localparam int SPK_SIGN_BIT = 29;
  localparam int SPK_GEN_LSB  = 21;
  localparam int SPK_TAG_LSB  = 10;

endpackage

/* design/hostWordDecoder.sv */
`timescale 1ns/1ps
`include "bdHostDefs_defs.svh"

module hostWordDecoder (
  input  logic                           okClk,
  input  logic                           rstN,
  input  logic                           hostValid,
  input  bdWordPkg::hostWord_u           hostData,
  output logic                           bdWordValid,
  output logic [`BD_WORD_W-1:0]          bdWord,
  output logic                           coreReset,
  output logic [`BD_NUM_GENS-1:0]        genLoad,
  output logic [spikeGenPkg::PROG_W-1:0] genProgram,
  output logic [`BD_NUM_GENS-1:0]        genRun
);
  import bdWordPkg::*;
  import spikeGenPkg::*;

  localparam int ASM_W = 64;  // four 16-bit pieces

  logic [1:0]              wordKind;
  logic [5:0]              regId;
  logic [15:0]             regData;
  logic [7:0]              epId;
  logic [23:0]             epPayload;
  logic [15:0]             gensUsed;
  logic [`BD_NUM_GENS-1:0] genEnable;
  logic [ASM_W-1:0]        progAsm;
  logic [ASM_W-1:0]        progAsmNext;
  logic [1:0]              pieceCnt;
  logic [PROG_GEN_W-1:0]   loadIdx;
  logic                    progPiece;

  // ------------------------------------------------------------
  // field extraction, both views of the same word
  // ------------------------------------------------------------

  assign wordKind  = hostData.rg[1][15:14];
  assign regId     = hostData.rg[1][13:8];
  assign regData   = hostData.rg[0];
  assign epId      = hostData.ep[3];     // kind bits included
  assign epPayload = hostData.ep[2:0];

  assign progPiece = hostValid && (wordKind == KIND_EP) && (epId == EP_GEN_PROG);

  // new piece enters at the top, lowest piece ends up in 15:0
  assign progAsmNext = {epPayload[15:0], progAsm[ASM_W-1:16]};
  assign loadIdx     = progAsmNext[PROG_GEN_LSB +: PROG_GEN_W];

  // ------------------------------------------------------------
  // control registers
  // ------------------------------------------------------------

  always_ff @(posedge okClk) begin
    if (!rstN) begin
      coreReset   <= 1'b1;  // core comes up held
      gensUsed    <= '0;
      genEnable   <= '0;
      pieceCnt    <= '0;
      genLoad     <= '0;
      bdWordValid <= 1'b0;
    end else begin
      bdWordValid <= hostValid && (wordKind == KIND_BD);
      genLoad     <= '0;  // strobe

      if (hostValid && (wordKind == KIND_REG)) begin
        case (regId)
          REG_RESET: coreReset <= regData[0];
          REG_NOP:   ;  // pipe filler
          default:   ;  // other ids are kept on the chip side
        endcase
      end

      if (hostValid && (wordKind == KIND_EP)) begin
        case (epId)
          EP_GENS_USED:  gensUsed  <= epPayload[15:0];
          EP_GEN_ENABLE: genEnable <= epPayload[`BD_NUM_GENS-1:0];
          default:       ;  // program pieces go through progPiece
        endcase
      end

      // piece counter, restarts whenever the core is held
      if (coreReset) begin
        pieceCnt <= '0;
      end else if (progPiece) begin
        pieceCnt <= pieceCnt + 1'b1;
        if (pieceCnt == 2'd3) begin
          // fourth piece, index out of range loads nobody
          for (int g = 0; g < `BD_NUM_GENS; g++) begin
            if (loadIdx == PROG_GEN_W'(g)) genLoad[g] <= 1'b1;
          end
        end
      end
    end
  end

  // payload, no reset needed
  always_ff @(posedge okClk) begin
    bdWord <= hostData;
    if (progPiece) progAsm <= progAsmNext;
  end

  assign genProgram = progAsm[PROG_W-1:0];

  // run = enabled, inside the in-use count, core not held
  always_comb begin
    for (int g = 0; g < `BD_NUM_GENS; g++) begin
      genRun[g] = genEnable[g] && (gensUsed > 16'(g)) && !coreReset;
    end
  end

  // one program word reaches at most one generator
  aOneLoad: assert property (@(posedge okClk) disable iff (!rstN) $onehot0(genLoad));

endmodule

/* design/spikeGen.sv */
`timescale 1ns/1ps
`include "bdHostDefs_defs.svh"

module spikeGen #(
  parameter int GEN_INDEX = 0  // slot in the bank, goes into the spike word
) (
  input  logic                           okClk,
  input  logic                           rstN,
  input  logic                           run,
  input  logic                           load,
  input  logic [spikeGenPkg::PROG_W-1:0] genProgram,
  input  logic                           grant,
  output logic                           pending,
  output logic [`BD_WORD_W-1:0]          spikeWord
);
  import spikeGenPkg::*;

  logic [PROG_TIME_W-1:0] period;
  logic [PROG_TIME_W-1:0] periodLast;
  logic [PROG_TIME_W-1:0] count;
  logic [PROG_TAG_W-1:0]  tag;
  logic                   sign;
  logic                   counting;
  logic                   atLast;

  // ------------------------------------------------------------
  // period counter
  // ------------------------------------------------------------

  assign periodLast = period - 1'b1;
  assign atLast     = (count >= periodLast);  // ticks may start past the end

  // unprogrammed slot (period 0) never counts
  assign counting = run && !pending && (period != '0);

  always_ff @(posedge okClk) begin
    if (!rstN) begin
      pending <= 1'b0;
      count   <= '0;
      period  <= '0;
    end else begin
      if (grant) pending <= 1'b0;
      else if (counting && atLast) pending <= 1'b1;  // count holds from here

      if (load) begin
        period <= genProgram[PROG_PERIOD_LSB +: PROG_TIME_W];
        count  <= genProgram[PROG_TICKS_LSB +: PROG_TIME_W];
      end else if (grant) begin
        count <= '0;  // restart after the merger took it
      end else if (counting && !atLast) begin
        count <= count + 1'b1;
      end
    end
  end

  // spike fields, plain payload
  always_ff @(posedge okClk) begin
    if (load) begin
      tag  <= genProgram[PROG_TAG_LSB +: PROG_TAG_W];
      sign <= genProgram[PROG_SIGN_BIT];
    end
  end

  // ------------------------------------------------------------
  // spike word
  // ------------------------------------------------------------

  always_comb begin
    spikeWord = '0;
    spikeWord[`BD_WORD_W-1 -: 2]             = SPIKE_KIND;
    spikeWord[SPK_SIGN_BIT]                  = sign;
    spikeWord[SPK_GEN_LSB +: PROG_GEN_W]     = PROG_GEN_W'(GEN_INDEX);
    spikeWord[SPK_TAG_LSB +: PROG_TAG_W]     = tag;
  end

  // a zero period would stall the slot for good
  aLoadPeriod: assert property (@(posedge okClk) disable iff (!rstN)
    load |-> (genProgram[PROG_PERIOD_LSB +: PROG_TIME_W] != '0));

  // merger only grants what is waiting
  aGrantPending: assert property (@(posedge okClk) disable iff (!rstN)
    grant |-> pending);

endmodule

/* design/bdOutMerger.sv */
`timescale 1ns/1ps
`include "bdHostDefs_defs.svh"

module bdOutMerger (
  input  logic                                    okClk,
  input  logic                                    rstN,
  input  logic                                    coreReset,
  input  logic                                    bdWordValid,
  input  logic [`BD_WORD_W-1:0]                   bdWord,
  input  logic [`BD_NUM_GENS-1:0]                 spikePending,
  input  logic [`BD_NUM_GENS-1:0][`BD_WORD_W-1:0] spikeWord,
  input  logic                                    bdOutReady,
  output logic [`BD_NUM_GENS-1:0]                 spikeGrant,
  output logic                                    bdOutValid,
  output logic [`BD_WORD_W-1:0]                   bdOutData,
  output logic                                    bdOverflow
);
  localparam int QA_W      = $clog2(`BD_QUEUE_DEPTH);
  localparam int GEN_IDX_W = (`BD_NUM_GENS > 1) ? $clog2(`BD_NUM_GENS) : 1;

  logic [`BD_WORD_W-1:0] queueMem [`BD_QUEUE_DEPTH];
  logic [QA_W-1:0]       wrPtr;
  logic [QA_W-1:0]       rdPtr;
  logic [QA_W:0]         qCount;
  logic                  qEmpty, qFull;
  logic                  outFree, bdAvail;
  logic                  takeBd, bypass, pop, push, drop, takeSpike;
  logic [GEN_IDX_W-1:0]  lastGrant, rrSel;
  logic                  rrHit;

  // ------------------------------------------------------------
  // who fills the output register this cycle
  // ------------------------------------------------------------

  assign qEmpty  = (qCount == '0);
  assign qFull   = (qCount == (QA_W+1)'(`BD_QUEUE_DEPTH));
  assign outFree = !bdOutValid || bdOutReady;  // empty or draining now

  assign bdAvail   = !coreReset && (!qEmpty || bdWordValid);
  assign takeBd    = outFree && bdAvail;       // chip words always first
  assign bypass    = takeBd && qEmpty;         // straight from the decoder
  assign pop       = takeBd && !qEmpty;
  assign push      = !coreReset && bdWordValid && !bypass && (!qFull || pop);
  assign drop      = !coreReset && bdWordValid && !bypass && qFull && !pop;
  assign takeSpike = outFree && !bdAvail && rrHit && !coreReset;

  // next pending slot after the last grant
  always_comb begin : rrPick
    int idx;
    rrSel = lastGrant;
    rrHit = 1'b0;
    for (int k = 1; k <= `BD_NUM_GENS; k++) begin
      idx = (int'(lastGrant) + k) % `BD_NUM_GENS;
      if (!rrHit && spikePending[idx]) begin
        rrSel = GEN_IDX_W'(idx);
        rrHit = 1'b1;
      end
    end
  end

  always_comb begin
    spikeGrant = '0;
    if (takeSpike) spikeGrant[rrSel] = 1'b1;
  end

  // ------------------------------------------------------------
  // queue pointers, arbiter state, output valid
  // ------------------------------------------------------------

  always_ff @(posedge okClk) begin
    if (!rstN || coreReset) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      qCount    <= '0;
      lastGrant <= GEN_IDX_W'(`BD_NUM_GENS - 1);  // slot 0 wins first
    end else begin
      if (push) wrPtr <= wrPtr + 1'b1;  // depth is a power of two
      if (pop) rdPtr <= rdPtr + 1'b1;
      case ({push, pop})
        2'b10:   qCount <= qCount + 1'b1;
        2'b01:   qCount <= qCount - 1'b1;
        default: ;
      endcase
      if (takeSpike) lastGrant <= rrSel;
    end
  end

  // valid and overflow follow rstN only, a word in flight finishes
  always_ff @(posedge okClk) begin
    if (!rstN) begin
      bdOutValid <= 1'b0;
      bdOverflow <= 1'b0;
    end else begin
      if (takeBd || takeSpike) bdOutValid <= 1'b1;
      else if (bdOutReady) bdOutValid <= 1'b0;
      if (drop) bdOverflow <= 1'b1;  // sticky
    end
  end

  always_ff @(posedge okClk) begin
    if (push) queueMem[wrPtr] <= bdWord;
    if (takeBd) bdOutData <= bypass ? bdWord : queueMem[rdPtr];
    else if (takeSpike) bdOutData <= spikeWord[rrSel];
  end

  // chip port holds data under back-pressure
  aHoldData: assert property (@(posedge okClk) disable iff (!rstN)
    (bdOutValid && !bdOutReady) |=> (bdOutValid && $stable(bdOutData)));

  aOneGrant: assert property (@(posedge okClk) disable iff (!rstN) $onehot0(spikeGrant));

endmodule

/* design/bdHostCore.sv */
`timescale 1ns/1ps
`include "bdHostDefs_defs.svh"

module bdHostCore (
  input  logic                  okClk,
  input  logic                  rstN,
  input  logic                  hostValid,  // one word per strobe, no ready
  input  logic [`BD_WORD_W-1:0] hostData,
  input  logic                  bdOutReady,
  output logic                  bdOutValid,
  output logic [`BD_WORD_W-1:0] bdOutData,
  output logic                  bdOverflow
);
  import spikeGenPkg::*;

  logic                                    bdWordValid;
  logic [`BD_WORD_W-1:0]                   bdWord;
  logic                                    coreReset;
  logic [`BD_NUM_GENS-1:0]                 genLoad;
  logic [PROG_W-1:0]                       genProgram;
  logic [`BD_NUM_GENS-1:0]                 genRun;
  logic [`BD_NUM_GENS-1:0]                 spikePending;
  logic [`BD_NUM_GENS-1:0]                 spikeGrant;
  logic [`BD_NUM_GENS-1:0][`BD_WORD_W-1:0] spikeWord;

  // ------------------------------------------------------------
  // host word decode
  // ------------------------------------------------------------

  hostWordDecoder i_hostWordDecoder (
    .okClk       (okClk),
    .rstN        (rstN),
    .hostValid   (hostValid),
    .hostData    (hostData),
    .bdWordValid (bdWordValid),
    .bdWord      (bdWord),
    .coreReset   (coreReset),
    .genLoad     (genLoad),
    .genProgram  (genProgram),
    .genRun      (genRun)
  );

  // ------------------------------------------------------------
  // generator bank, program bus shared, load picks the slot
  // ------------------------------------------------------------

  for (genvar g = 0; g < `BD_NUM_GENS; g++) begin : genBank
    spikeGen #(
      .GEN_INDEX (g)
    ) i_spikeGen (
      .okClk      (okClk),
      .rstN       (rstN),
      .run        (genRun[g]),
      .load       (genLoad[g]),
      .genProgram (genProgram),
      .grant      (spikeGrant[g]),
      .pending    (spikePending[g]),
      .spikeWord  (spikeWord[g])
    );
  end

  // chip words and spikes onto the one chip port
  bdOutMerger i_bdOutMerger (
    .okClk        (okClk),
    .rstN         (rstN),
    .coreReset    (coreReset),
    .bdWordValid  (bdWordValid),
    .bdWord       (bdWord),
    .spikePending (spikePending),
    .spikeWord    (spikeWord),
    .bdOutReady   (bdOutReady),
    .spikeGrant   (spikeGrant),
    .bdOutValid   (bdOutValid),
    .bdOutData    (bdOutData),
    .bdOverflow   (bdOverflow)
  );

endmodule

/* sim/bdHostCore_tb.sv */
`timescale 1ns/1ps
`include "bdHostDefs_defs.svh"

module bdHostCore_tb;
  import bdWordPkg::*;

  logic                  okClk;
  logic                  rstN;
  logic                  hostValid;
  logic [`BD_WORD_W-1:0] hostData;
  logic                  bdOutReady;
  logic                  bdOutValid;
  logic [`BD_WORD_W-1:0] bdOutData;
  logic                  bdOverflow;

  integer                  seed = 66;
  int                      readyMode;  // 0 low, 1 high, 2 random
  logic [`BD_WORD_W-1:0]   refQueue[$];
  logic [`BD_NUM_GENS-1:0] allowedGens;  // enabled and inside the in-use count
  logic                    progSign [`BD_NUM_GENS];
  logic [10:0]             progTag [`BD_NUM_GENS];
  int                      progPeriod [`BD_NUM_GENS];
  int                      spikeCount [`BD_NUM_GENS];
  longint                  lastSpike [`BD_NUM_GENS];
  longint                  cycleCnt;
  logic                    quietPhase;
  int                      spacingGen;
  logic                    rrCheck;
  int                      prevGen;

  bdHostCore i_bdHostCore (
    .okClk      (okClk),
    .rstN       (rstN),
    .hostValid  (hostValid),
    .hostData   (hostData),
    .bdOutReady (bdOutReady),
    .bdOutValid (bdOutValid),
    .bdOutData  (bdOutData),
    .bdOverflow (bdOverflow)
  );

  // ------------------------------------------------------------
  // clock, ready driver, cycle count
  // ------------------------------------------------------------

  initial okClk = 1'b0;
  always #4 okClk = ~okClk;  // 8 ns

  always @(posedge okClk) begin
    cycleCnt <= cycleCnt + 1;
    #1;
    case (readyMode)
      0:       bdOutReady = 1'b0;
      1:       bdOutReady = 1'b1;
      default: bdOutReady = 1'($random(seed));  // stall phase
    endcase
  end

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopping on first error");
  endtask

  // ------------------------------------------------------------
  // output checking, sampled mid-cycle where everything is settled
  // ------------------------------------------------------------

  task automatic checkWord(input logic [`BD_WORD_W-1:0] w);
    logic [`BD_WORD_W-1:0] expWord;
    int                    g;
    if (w[31:30] == 2'b00) begin
      assert (refQueue.size() > 0)
        else reportFailure($sformatf("chip word %h came out with none expected", w));
      expWord = refQueue.pop_front();
      assert (w == expWord)
        else reportFailure($sformatf("mismatch bdOutData: got %h expected %h", w, expWord));
    end else begin
      assert (w[31:30] == 2'b01)
        else reportFailure($sformatf("mismatch bdOutData kind: got %h expected 1", w[31:30]));
      g = int'(w[28:21]);
      assert (g < `BD_NUM_GENS && allowedGens[g])
        else reportFailure($sformatf("spike from generator %0d which should be idle", g));
      assert (w[29] == progSign[g])
        else reportFailure($sformatf("mismatch bdOutData sign: got %h expected %h",
                                     w[29], progSign[g]));
      assert (w[20:10] == progTag[g])
        else reportFailure($sformatf("mismatch bdOutData tag: got %h expected %h",
                                     w[20:10], progTag[g]));
      assert (w[9:0] == 10'h0)
        else reportFailure($sformatf("mismatch bdOutData low bits: got %h expected 0",
                                     w[9:0]));
      if (g == spacingGen && lastSpike[g] >= 0) begin
        assert (cycleCnt - lastSpike[g] >= longint'(progPeriod[g]))
          else reportFailure($sformatf("generator %0d spiked %0d cycles apart, period %0d",
                                       g, cycleCnt - lastSpike[g], progPeriod[g]));
      end
      if (rrCheck && prevGen >= 0) begin
        assert (g == (prevGen + 1) % `BD_NUM_GENS)
          else reportFailure($sformatf("mismatch bdOutData generator: got %h expected %h",
                                       g, (prevGen + 1) % `BD_NUM_GENS));
      end
      prevGen      = g;
      lastSpike[g] = cycleCnt;
      spikeCount[g]++;
    end
  endtask

  always @(negedge okClk) begin
    if (rstN) begin
      assert (!(quietPhase && bdOutValid))
        else reportFailure("output went valid while the core was held in soft reset");
      if (bdOutValid && bdOutReady) checkWord(bdOutData);
    end
  end

  // ------------------------------------------------------------
  // host stimulus, one word per cycle, valid left high
  // ------------------------------------------------------------

  task automatic putWord(input logic [`BD_WORD_W-1:0] w);
    @(posedge okClk);
    #1;
    hostValid = 1'b1;
    hostData  = w;
  endtask

  task automatic hostIdle();
    @(posedge okClk);
    #1;
    hostValid = 1'b0;
  endtask

  task automatic sendBd(input logic expectOut);
    logic [`BD_WORD_W-1:0] w;
    w = {2'b00, 30'($random(seed))};  // leaf code and payload
    putWord(w);
    if (expectOut) refQueue.push_back(w);
  endtask

  task automatic setReg(input logic [5:0] id, input logic [15:0] data);
    putWord({KIND_REG, id, 8'h00, data});
  endtask

  task automatic sendEp(input logic [7:0] id, input logic [23:0] payload);
    putWord({id, payload});
  endtask

  task automatic progGen(input int g, input logic sign, input int period, input logic [10:0] tag);
    logic [63:0] prog;
    prog = {12'h0, sign, 8'(g), 16'(period), 16'h0, tag};  // ticks 0
    for (int i = 0; i < 4; i++) sendEp(EP_GEN_PROG, {8'h0, prog[16*i +: 16]});
    progSign[g]   = sign;
    progTag[g]    = tag;
    progPeriod[g] = period;
  endtask

  // ------------------------------------------------------------
  // waits, each bounded
  // ------------------------------------------------------------

  task automatic waitDrained(input int timeout);
    int idle;
    int n;
    idle = 0;
    n    = 0;
    while (idle < 20 || refQueue.size() > 0) begin
      @(posedge okClk);
      idle = bdOutValid ? 0 : idle + 1;
      n++;
      if (n > timeout) reportFailure("timeout waiting for the output to drain");
    end
  endtask

  task automatic waitSpikes(input int need, input int timeout);
    int base [`BD_NUM_GENS];
    int n;
    logic done;
    for (int g = 0; g < `BD_NUM_GENS; g++) base[g] = spikeCount[g];
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge okClk);
      done = 1'b1;
      for (int g = 0; g < `BD_NUM_GENS; g++) begin
        if (allowedGens[g] && spikeCount[g] - base[g] < need) done = 1'b0;
      end
      n++;
      if (n > timeout) reportFailure("timeout waiting for spikes from enabled generators");
    end
  endtask

  task automatic idleWindow(input int cycles);
    for (int i = 0; i < cycles; i++) @(posedge okClk);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin
    rstN = 1'b0;
    hostValid = 1'b0;
    hostData = '0;
    bdOutReady = 1'b0;
    readyMode = 1;
    cycleCnt = 0;
    allowedGens = '0;
    quietPhase = 1'b1;
    spacingGen = -1;
    rrCheck = 1'b0;
    prevGen = -1;
    for (int g = 0; g < `BD_NUM_GENS; g++) begin
      spikeCount[g] = 0;
      lastSpike[g]  = -1;
      progPeriod[g] = 1;
    end
    repeat (3) @(posedge okClk);
    #1 rstN = 1'b1;

    // held in soft reset, nothing may leave
    sendEp(EP_GENS_USED, 24'd4);
    sendEp(EP_GEN_ENABLE, 24'hf);
    progGen(0, 1'b1, 2, 11'h7ff);
    sendBd(1'b0);
    hostIdle();
    idleWindow(30);
    sendEp(EP_GEN_ENABLE, 24'h0);
    setReg(REG_RESET, 16'h0000);
    quietPhase = 1'b0;

    // pass-through under random back-pressure
    readyMode = 2;
    for (int i = 0; i < 24; i++) begin
      sendBd(1'b1);
      hostIdle();  // host has no ready, give the drain some room
      idleWindow(3);
      if (i % 5 == 2) setReg(REG_NOP, 16'hbeef);
      if (i % 7 == 3) setReg(6'd5, 16'h1234);
    end
    hostIdle();
    waitDrained(3000);

    // spike format, all four mixed with chip words
    for (int g = 0; g < `BD_NUM_GENS; g++) begin
      progGen(g, g[0], 3 + g, 11'(11'h100 + g * 37));
    end
    sendEp(EP_GENS_USED, 24'd4);
    allowedGens = 4'hf;
    sendEp(EP_GEN_ENABLE, 24'hf);
    for (int i = 0; i < 10; i++) begin
      sendBd(1'b1);
      hostIdle();
      idleWindow(3);
    end
    hostIdle();
    waitSpikes(3, 3000);
    sendEp(EP_GEN_ENABLE, 24'h0);
    hostIdle();
    waitDrained(3000);
    allowedGens = '0;

    // spacing of a single generator
    readyMode = 1;
    progGen(1, 1'b0, 7, 11'h055);
    spacingGen = 1;
    allowedGens = 4'b0010;
    sendEp(EP_GEN_ENABLE, 24'h2);
    hostIdle();
    waitSpikes(5, 2000);
    sendEp(EP_GEN_ENABLE, 24'h0);
    hostIdle();
    waitDrained(1000);
    allowedGens = '0;
    spacingGen = -1;

    // enabled but outside the in-use count
    sendEp(EP_GENS_USED, 24'd2);
    sendEp(EP_GEN_ENABLE, 24'hc);
    hostIdle();
    idleWindow(60);
    sendEp(EP_GEN_ENABLE, 24'h0);
    sendEp(EP_GENS_USED, 24'd4);
    hostIdle();
    waitDrained(1000);

    // round-robin, every slot at period 1
    for (int g = 0; g < `BD_NUM_GENS; g++) begin
      progGen(g, ~g[0], 1, 11'(11'h020 + g * 5));
    end
    allowedGens = 4'hf;
    rrCheck = 1'b1;
    prevGen = -1;
    sendEp(EP_GEN_ENABLE, 24'hf);
    hostIdle();
    waitSpikes(8, 2000);
    rrCheck = 1'b0;
    sendEp(EP_GEN_ENABLE, 24'h0);
    hostIdle();
    waitDrained(1000);
    allowedGens = '0;

    // overflow, output register plus a full queue, sixth word lost
    readyMode = 0;
    idleWindow(3);
    assert (!bdOverflow)
      else reportFailure($sformatf("mismatch bdOverflow: got %h expected 0", bdOverflow));
    for (int i = 0; i < 6; i++) sendBd(i <= `BD_QUEUE_DEPTH);
    hostIdle();
    idleWindow(3);
    assert (bdOverflow)
      else reportFailure($sformatf("mismatch bdOverflow: got %h expected 1", bdOverflow));
    readyMode = 1;
    waitDrained(1000);

    $display("Regression passed");
    $finish;
  end

endmodule

/* tb.f */
+incdir+design
design/bdWordPkg.sv
design/spikeGenPkg.sv
design/hostWordDecoder.sv
design/spikeGen.sv
design/bdOutMerger.sv
design/bdHostCore.sv
sim/bdHostCore_tb.sv

/* Makefile */
# Verilator build and run for the host bridge testbench

VERILATOR ?= verilator
TOP       ?= bdHostCore_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard design/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
